// File: execute_unit.f
+incdir+logic
logic/cpu_pkg.sv
logic/alu.sv
logic/divider.sv
logic/exe_stage.sv
logic/data_ram.sv
logic/mem_stage.sv
logic/execute_unit.sv
tb/tb_execute_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_execute_unit
SEED      ?= 79122
FLIST     ?= execute_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_execute_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_execute_unit
    import cpu_pkg::*;
#(
    parameter int SEED = 79122
);

    localparam int HALF_PERIOD  = 50;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 10;

    logic      clk;
    logic      reset;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    logic      es_allowin;
    logic      ws_allowin;
    logic      ms_to_ws_valid;
    ms_to_ws_t ms_to_ws_bus;
    fwd_t      es_fwd;
    fwd_t      ms_fwd;

    ds_to_es_t   stim[$];
    ms_to_ws_t   exp_tab[$];
    fwd_t        fwd_tab[$];
    ms_to_ws_t   exp_q[$];
    logic [7:0]  shadow [0:(1 << (`DMEM_AW + 2))-1];    // byte image of the data RAM.
    logic [31:0] rng = SEED;
    int          checked = 0;
    logic        built = 1'b0;

    execute_unit i_execute_unit (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd)
    );

    function automatic logic [31:0] rand32();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped after a failure.");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            stop_run($sformatf("[ERROR] %0t ns: %s got %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_ms_to_ws(input ms_to_ws_t got, input ms_to_ws_t exp);
        if (got !== exp)
        begin
            stop_run($sformatf("[ERROR] %0t ns: ms_to_ws_bus got %h, expected %h",
                               $time, got, exp));
        end
    endtask

    task automatic check_fwd(input string name, input fwd_t got, input fwd_t exp);
        if (got !== exp)
        begin
            stop_run($sformatf("[ERROR] %0t ns: %s got %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] div_ref(input logic [31:0] a, input logic [31:0] b,
                                            input logic sgn, input logic want_rem);
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] m;
        if (b == 32'd0)
        begin
            return want_rem ? a : 32'hffff_ffff;
        end
        ma = (sgn && a[31]) ? 32'd0 - a : a;
        mb = (sgn && b[31]) ? 32'd0 - b : b;
        q  = ma / mb;
        m  = ma % mb;
        if (sgn && (a[31] != b[31]))
        begin
            q = 32'd0 - q;
        end
        if (sgn && a[31])
        begin
            m = 32'd0 - m;    // remainder follows the dividend.
        end
        return want_rem ? m : q;
    endfunction

    // the reference model also updates the shadow RAM for stores.
    task automatic predict(input ds_to_es_t d, output ms_to_ws_t e, output fwd_t f);
        logic [31:0]         s1;
        logic [31:0]         s2;
        logic [31:0]         r;
        logic [31:0]         word;
        logic [31:0]         lane;
        logic [31:0]         rep;
        logic [63:0]         ps;
        logic [63:0]         pu;
        logic [3:0]          strb;
        logic [`DMEM_AW+1:0] ba;
        logic                is_ld;
        s1 = d.src1_is_pc ? d.pc : d.rj_value;
        s2 = d.src2_is_imm ? d.imm : d.rkd_value;
        case (d.alu_op)
            alu_add:  r = s1 + s2;
            alu_sub:  r = s1 + ~s2 + 32'd1;
            alu_slt:  r = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
            alu_sltu: r = (s1 < s2) ? 32'd1 : 32'd0;
            alu_and:  r = s1 & s2;
            alu_or:   r = s1 | s2;
            alu_nor:  r = ~s1 & ~s2;
            alu_xor:  r = s1 ^ s2;
            alu_sll:  r = s1 << s2[4:0];
            alu_srl:  r = s1 >> s2[4:0];
            alu_sra:  r = 32'(({{32{s1[31]}}, s1}) >> s2[4:0]);
            alu_lui:  r = s2;
            default:  r = 32'd0;
        endcase
        ps = {{32{s1[31]}}, s1} * {{32{s2[31]}}, s2};    // low 64 bits equal the signed product.
        pu = {32'd0, s1} * {32'd0, s2};
        case (d.md_op)
            md_mul:   r = ps[31:0];
            md_mulh:  r = ps[63:32];
            md_mulhu: r = pu[63:32];
            md_div:   r = div_ref(s1, s2, 1'b1, 1'b0);
            md_mod:   r = div_ref(s1, s2, 1'b1, 1'b1);
            md_divu:  r = div_ref(s1, s2, 1'b0, 1'b0);
            md_modu:  r = div_ref(s1, s2, 1'b0, 1'b1);
            default:
            begin
            end
        endcase
        is_ld = d.mem_op inside {mem_ld_b, mem_ld_h, mem_ld_w, mem_ld_bu, mem_ld_hu};
        f     = '{valid: d.gr_we, blocked: is_ld, dest: d.dest, value: r};    // execute view.
        ba = r[`DMEM_AW+1:0];
        for (int b = 0; b < 4; b++)
        begin
            word[8*b +: 8] = shadow[{ba[`DMEM_AW+1:2], 2'(b)}];
        end
        lane = word >> (8 * ba[1:0]);
        rep  = (d.mem_op == mem_st_b) ? {4{d.rkd_value[7:0]}} :
               (d.mem_op == mem_st_h) ? {2{d.rkd_value[15:0]}} : d.rkd_value;
        strb = (d.mem_op == mem_st_b) ? (4'b0001 << ba[1:0]) :
               (d.mem_op == mem_st_h) ? (4'b0011 << ba[1:0]) : 4'b1111;
        case (d.mem_op)
            mem_ld_b:  r = {{24{lane[7]}}, lane[7:0]};
            mem_ld_bu: r = {24'd0, lane[7:0]};
            mem_ld_h:  r = {{16{lane[15]}}, lane[15:0]};
            mem_ld_hu: r = {16'd0, lane[15:0]};
            mem_ld_w:  r = word;
            mem_st_b, mem_st_h, mem_st_w:
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (strb[b])
                    begin
                        shadow[{ba[`DMEM_AW+1:2], 2'(b)}] = rep[8*b +: 8];
                    end
                end
            end
            default:
            begin
            end
        endcase
        e = '{gr_we: d.gr_we, dest: d.dest, result: r, pc: d.pc};
    endtask

    task automatic add_entry(input alu_op_t aop, input md_op_t mop, input mem_op_t mmop,
                             input logic pc_sel, input logic imm_sel, input logic we,
                             input logic [31:0] imm, input logic [31:0] rj,
                             input logic [31:0] rkd);
        ds_to_es_t d;
        d = '{alu_op: aop, md_op: mop, mem_op: mmop, src1_is_pc: pc_sel,
              src2_is_imm: imm_sel, gr_we: we, dest: 5'(stim.size()), imm: imm,
              rj_value: rj, rkd_value: rkd, pc: 32'h1c00_0000 + 32'(4 * stim.size())};
        stim.push_back(d);
    endtask

    task automatic build_table();
        logic [31:0] pa [6];
        logic [31:0] pb [6];
        logic [31:0] r;
        md_op_t      md;
        for (int k = 0; k < 12; k++)
        begin
            add_entry(alu_op_t'(k), md_none, mem_none, 1'b0, 1'b0, 1'b1,
                      rand32(), rand32(), rand32());
            add_entry(alu_op_t'(k), md_none, mem_none, 1'b1, 1'b1, 1'b1,
                      rand32(), rand32(), rand32());
        end
        add_entry(alu_slt, md_none, mem_none, 1'b0, 1'b0, 1'b1, 0, 32'h8000_0000, 32'd1);
        add_entry(alu_sltu, md_none, mem_none, 1'b0, 1'b0, 1'b1, 0, 32'h8000_0000, 32'd1);
        add_entry(alu_sra, md_none, mem_none, 1'b0, 1'b1, 1'b1, 32'd31, 32'h8000_0000, 0);
        add_entry(alu_sll, md_none, mem_none, 1'b0, 1'b1, 1'b1, 32'h0000_0023, 32'd1, 0);
        pa = '{32'h8000_0001, 32'h7fff_ffff, 32'hffff_fff3, 32'hffff_fff9, 32'h0000_0007,
               32'h8000_0000};
        pb = '{32'hffff_fffe, 32'h8000_0000, 32'h0000_0011, 32'h0000_0002, 32'hffff_fffe,
               32'hffff_ffff};
        for (int m = 1; m < 8; m++)
        begin
            for (int p = 0; p < 6; p++)
            begin
                add_entry(alu_add, md_op_t'(m), mem_none, 1'b0, 1'b0, 1'b1, 0, pa[p], pb[p]);
            end
            add_entry(alu_add, md_op_t'(m), mem_none, 1'b0, 1'b0, 1'b1, 0, rand32(), 32'd0);
        end
        for (int w = 0; w < 3; w++)
        begin
            add_entry(alu_add, md_none, mem_st_w, 1'b0, 1'b1, 1'b0, 32'(4 * w), 32'h100, rand32());
        end
        for (int o = 0; o < 4; o++)
        begin
            add_entry(alu_add, md_none, mem_st_b, 1'b0, 1'b1, 1'b0, 32'(o), 32'h100, rand32());
            add_entry(alu_add, md_none, mem_st_h, 1'b0, 1'b1, 1'b0, 32'(o), 32'h104, rand32());
            add_entry(alu_add, md_none, mem_st_w, 1'b0, 1'b1, 1'b0, 32'(o), 32'h108, rand32());
        end
        for (int w = 0; w < 3; w++)
        begin
            add_entry(alu_add, md_none, mem_ld_w, 1'b0, 1'b1, 1'b1, 32'(4 * w), 32'h100, 0);
            for (int o = 0; o < 4; o++)
            begin
                add_entry(alu_add, md_none, mem_ld_b, 1'b0, 1'b1, 1'b1, 32'(4*w+o), 32'h100, 0);
                add_entry(alu_add, md_none, mem_ld_bu, 1'b0, 1'b1, 1'b1, 32'(4*w+o), 32'h100, 0);
                add_entry(alu_add, md_none, mem_ld_h, 1'b0, 1'b1, 1'b1, 32'(4*w+o), 32'h100, 0);
                add_entry(alu_add, md_none, mem_ld_hu, 1'b0, 1'b1, 1'b1, 32'(4*w+o), 32'h100, 0);
            end
        end
        for (int n = 0; n < 40; n++)
        begin
            r  = rand32();
            md = md_none;
            if (r[2:0] == 3'd0)
            begin
                md = md_op_t'({1'b1, r[4:3]});    // one of the four divide ops.
            end
            else if (r[2:0] == 3'd1)
            begin
                md = md_op_t'(3'(1 + (r[4:3] % 3)));
            end
            add_entry(alu_op_t'(4'(r[11:8] % 12)), md, mem_none, r[13], r[14], r[12],
                      rand32(), rand32(), rand32());
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ws_allowin is high about three cycles in four.
    initial
    begin
        forever
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            ws_allowin = (rand32() >> 20) % 4 != 0;
        end
    end

    initial
    begin
        wait (built);
        repeat (RESET_CYCLES + 20 + stim.size() * (`DIV_STEPS + 10)) @(posedge clk);
        stop_run("timeout: not all expected results came out of the DUT in time.");
    end

    initial
    begin
        ms_to_ws_t e;
        fwd_t      f;
        forever
        begin
            @(negedge clk);
            if (!reset && ms_to_ws_valid && ws_allowin)
            begin
                if (exp_q.size() == 0)
                begin
                    stop_run("the DUT delivered a result that was not expected.");
                end
                else
                begin
                    e = exp_q.pop_front();
                    f = '{valid: e.gr_we, blocked: 1'b0, dest: e.dest, value: e.result};
                    check_ms_to_ws(ms_to_ws_bus, e);
                    check_fwd("ms_fwd", ms_fwd, f);
                    checked++;
                end
            end
            else if (!reset && !ms_to_ws_valid)
            begin
                check_bit("ms_fwd.valid", ms_fwd.valid, 1'b0);
            end
        end
    end

    initial
    begin
        ms_to_ws_t e;
        fwd_t      f;
        logic      accepted;
        reset          = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        ws_allowin     = 1'b1;
        build_table();
        foreach (stim[i])
        begin
            predict(stim[i], e, f);
            exp_tab.push_back(e);
            fwd_tab.push_back(f);
        end
        built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        check_bit("ms_to_ws_valid", ms_to_ws_valid, 1'b0);
        check_bit("es_allowin", es_allowin, 1'b1);
        check_bit("es_fwd.valid", es_fwd.valid, 1'b0);
        check_bit("ms_fwd.valid", ms_fwd.valid, 1'b0);
        @(posedge clk);
        #DRIVE_DELAY;
        // the last pass only waits for the final entry to leave execute.
        for (int i = 0; i <= stim.size(); i++)
        begin
            if (i < stim.size())
            begin
                ds_to_es_valid = 1'b1;
                ds_to_es_bus   = stim[i];
                exp_q.push_back(exp_tab[i]);
            end
            else
            begin
                ds_to_es_valid = 1'b0;
            end
            accepted = 1'b0;
            while (!accepted)
            begin
                @(negedge clk);
                accepted = es_allowin;
                if (i == 0)
                begin
                    check_bit("es_fwd.valid", es_fwd.valid, 1'b0);
                end
                else if (accepted)
                begin
                    check_fwd("es_fwd", es_fwd, fwd_tab[i - 1]);    // previous entry leaves.
                end
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        wait (checked == stim.size());
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_bit("es_fwd.valid", es_fwd.valid, 1'b0);
        if (ms_to_ws_valid === 1'b0)
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            stop_run("the DUT still holds a result after all expected results came out.");
        end
    end

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_unit
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_to_es_valid,
    input  ds_to_es_t ds_to_es_bus,
    output logic      es_allowin,
    input  logic      ws_allowin,
    output logic      ms_to_ws_valid,
    output ms_to_ws_t ms_to_ws_bus,
    output fwd_t      es_fwd,
    output fwd_t      ms_fwd
);

    logic                es_to_ms_valid;
    es_to_ms_t           es_to_ms_bus;
    logic                ms_allowin;
    logic                ram_en;
    logic [3:0]          ram_wen;
    logic [`DMEM_AW-1:0] ram_addr;
    logic [`XLEN-1:0]    ram_wdata;
    logic [`XLEN-1:0]    ram_rdata;

    exe_stage u_exe_stage (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .es_fwd         (es_fwd),
        .ram_en         (ram_en),
        .ram_wen        (ram_wen),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .wen   (ram_wen),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ram_rdata      (ram_rdata),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ms_fwd         (ms_fwd)
    );

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module mem_stage
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             es_to_ms_valid,
    input  es_to_ms_t        es_to_ms_bus,
    output logic             ms_allowin,
    input  logic [`XLEN-1:0] ram_rdata,
    input  logic             ws_allowin,
    output logic             ms_to_ws_valid,
    output ms_to_ws_t        ms_to_ws_bus,
    output fwd_t             ms_fwd
);

    es_to_ms_t        ms_bus_r;
    logic             ms_valid;
    logic [`XLEN-1:0] ld_shifted;
    logic [`XLEN-1:0] ms_result;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ms_valid <= 1'b0;
        end
        else if (ms_allowin)
        begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (es_to_ms_valid && ms_allowin)
        begin
            ms_bus_r <= es_to_ms_bus;
        end
    end

    assign ld_shifted = ram_rdata >> {ms_bus_r.byte_off, 3'b000};

    always_comb
    begin
        case (ms_bus_r.mem_op)
            mem_ld_b:  ms_result = {{(`XLEN-8){ld_shifted[7]}}, ld_shifted[7:0]};
            mem_ld_bu: ms_result = {{(`XLEN-8){1'b0}}, ld_shifted[7:0]};
            mem_ld_h:  ms_result = {{(`XLEN-16){ld_shifted[15]}}, ld_shifted[15:0]};
            mem_ld_hu: ms_result = {{(`XLEN-16){1'b0}}, ld_shifted[15:0]};
            mem_ld_w:  ms_result = ram_rdata;
            default:   ms_result = ms_bus_r.result;    // stores and non-memory ops pass through.
        endcase
    end

    assign ms_to_ws_bus = '{
        gr_we:  ms_bus_r.gr_we,
        dest:   ms_bus_r.dest,
        result: ms_result,
        pc:     ms_bus_r.pc
    };

    assign ms_fwd = '{
        valid:   ms_valid && ms_bus_r.gr_we,
        blocked: 1'b0,
        dest:    ms_bus_r.dest,
        value:   ms_result
    };

    // load data must hold while stalled, which relies on exe_stage keeping ram_en low.
    assert property (@(posedge clk) disable iff (reset)
        ms_to_ws_valid && !ws_allowin |=> $stable(ms_to_ws_bus))
        else $error("ms_to_ws_bus changed under back-pressure.");

endmodule

// File: logic/data_ram.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module data_ram (
    input  logic                clk,
    input  logic                en,
    input  logic [3:0]          wen,
    input  logic [`DMEM_AW-1:0] addr,
    input  logic [`XLEN-1:0]    wdata,
    output logic [`XLEN-1:0]    rdata
);

    logic [`XLEN-1:0] mem [0:(1 << `DMEM_AW)-1];

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (wen[i])
                begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[addr];    // old data on a write, held while en is low.
        end
    end

endmodule

// File: logic/exe_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module exe_stage
    import cpu_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_to_es_valid,
    input  ds_to_es_t          ds_to_es_bus,
    output logic               es_allowin,
    input  logic               ms_allowin,
    output logic               es_to_ms_valid,
    output es_to_ms_t          es_to_ms_bus,
    output fwd_t               es_fwd,
    output logic               ram_en,
    output logic [3:0]         ram_wen,
    output logic [`DMEM_AW-1:0] ram_addr,
    output logic [`XLEN-1:0]   ram_wdata
);

    ds_to_es_t            es_bus_r;
    logic                 es_valid;
    logic                 es_ready_go;
    logic [`XLEN-1:0]     alu_src1;
    logic [`XLEN-1:0]     alu_src2;
    logic [`XLEN-1:0]     alu_result;
    logic [2*`XLEN-1:0]   prod_s;
    logic [2*`XLEN-1:0]   prod_u;
    logic                 is_div;
    logic                 div_signed;
    logic                 div_start;
    logic                 div_started;
    logic                 div_have;
    logic                 div_busy;
    logic                 div_done;
    logic [`XLEN-1:0]     div_quotient;
    logic [`XLEN-1:0]     div_remainder;
    logic [`XLEN-1:0]     quo_r;
    logic [`XLEN-1:0]     rem_r;
    logic [`XLEN-1:0]     div_quo;
    logic [`XLEN-1:0]     div_rem;
    logic                 is_load;
    logic                 is_store;
    logic [1:0]           byte_off;
    logic [`XLEN-1:0]     st_data;
    logic [3:0]           st_strb;
    logic [`XLEN-1:0]     es_result;

    assign is_div     = es_bus_r.md_op inside {md_div, md_mod, md_divu, md_modu};
    assign div_signed = es_bus_r.md_op inside {md_div, md_mod};
    assign is_load    = es_bus_r.mem_op inside {mem_ld_b, mem_ld_h, mem_ld_w, mem_ld_bu, mem_ld_hu};
    assign is_store   = es_bus_r.mem_op inside {mem_st_b, mem_st_h, mem_st_w};

    assign es_ready_go    = !is_div || div_done || div_have;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            es_valid    <= 1'b0;
            div_started <= 1'b0;
            div_have    <= 1'b0;
        end
        else if (es_allowin)
        begin
            es_valid    <= ds_to_es_valid;
            div_started <= 1'b0;
            div_have    <= 1'b0;
        end
        else
        begin
            if (div_start)
            begin
                div_started <= 1'b1;
            end
            if (div_done)
            begin
                div_have <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ds_to_es_valid && es_allowin)
        begin
            es_bus_r <= ds_to_es_bus;
        end
        if (div_done)
        begin
            quo_r <= div_quotient;
            rem_r <= div_remainder;
        end
    end

    assign alu_src1 = es_bus_r.src1_is_pc ? es_bus_r.pc : es_bus_r.rj_value;
    assign alu_src2 = es_bus_r.src2_is_imm ? es_bus_r.imm : es_bus_r.rkd_value;

    alu u_alu (
        .alu_op     (es_bus_r.alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    assign prod_s = $signed(alu_src1) * $signed(alu_src2);
    assign prod_u = alu_src1 * alu_src2;

    assign div_start = es_valid && is_div && !div_started && !div_busy;

    divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (alu_src1),
        .divisor   (alu_src2),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

    // in the done cycle the result comes straight from the divider.
    assign div_quo = div_have ? quo_r : div_quotient;
    assign div_rem = div_have ? rem_r : div_remainder;

    always_comb
    begin
        case (es_bus_r.md_op)
            md_mul:          es_result = prod_s[`XLEN-1:0];
            md_mulh:         es_result = prod_s[2*`XLEN-1:`XLEN];
            md_mulhu:        es_result = prod_u[2*`XLEN-1:`XLEN];
            md_div, md_divu: es_result = div_quo;
            md_mod, md_modu: es_result = div_rem;
            default:         es_result = alu_result;
        endcase
    end

    assign byte_off = alu_result[1:0];

    always_comb
    begin
        st_data = es_bus_r.rkd_value;
        st_strb = 4'b1111;
        case (es_bus_r.mem_op)
            mem_st_b:
            begin
                st_data = {4{es_bus_r.rkd_value[7:0]}};
                st_strb = 4'b0001 << byte_off;
            end
            mem_st_h:
            begin
                st_data = {2{es_bus_r.rkd_value[15:0]}};
                st_strb = 4'b0011 << byte_off;
            end
            default:
            begin
            end
        endcase
    end

    // the RAM is touched only on the move into mem_stage, so a store writes once.
    assign ram_en    = es_valid && es_ready_go && ms_allowin && (is_load || is_store);
    assign ram_wen   = (ram_en && is_store) ? st_strb : 4'b0000;
    assign ram_addr  = alu_result[`DMEM_AW+1:2];
    assign ram_wdata = st_data;

    assign es_to_ms_bus = '{
        mem_op:   es_bus_r.mem_op,
        gr_we:    es_bus_r.gr_we,
        dest:     es_bus_r.dest,
        byte_off: byte_off,
        result:   es_result,
        pc:       es_bus_r.pc
    };

    assign es_fwd = '{
        valid:   es_valid && es_bus_r.gr_we,
        blocked: es_valid && is_load,
        dest:    es_bus_r.dest,
        value:   es_result
    };

    // a stalled item must hold, including a divide result kept after the done pulse.
    assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin |=> es_to_ms_valid && $stable(es_to_ms_bus))
        else $error("es_to_ms_bus changed under back-pressure.");

endmodule

// File: logic/divider.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module divider (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             is_signed,
    input  logic [`XLEN-1:0] dividend,
    input  logic [`XLEN-1:0] divisor,
    output logic             busy,
    output logic             done,
    output logic [`XLEN-1:0] quotient,
    output logic [`XLEN-1:0] remainder
);

    localparam int CNT_W = $clog2(`DIV_STEPS + 1);

    logic [CNT_W-1:0] step_cnt;
    logic [`XLEN-1:0] dend_mag;
    logic [`XLEN-1:0] dsor_mag;
    logic [`XLEN-1:0] quo_r;
    logic [`XLEN-1:0] rem_r;
    logic [`XLEN-1:0] dsor_r;
    logic             neg_quo;
    logic             neg_rem;
    logic [`XLEN:0]   shifted;
    logic [`XLEN:0]   diff;

    assign dend_mag = (is_signed && dividend[`XLEN-1]) ? -dividend : dividend;
    assign dsor_mag = (is_signed && divisor[`XLEN-1]) ? -divisor : divisor;

    // partial remainder with the next dividend bit shifted in.
    assign shifted = {rem_r, quo_r[`XLEN-1]};
    assign diff    = shifted - {1'b0, dsor_r};    // top bit set means the trial failed.

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end
            else if (busy)
            begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == CNT_W'(`DIV_STEPS - 1))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            quo_r   <= dend_mag;
            rem_r   <= '0;
            dsor_r  <= dsor_mag;
            // a zero divisor keeps the all-ones quotient unsigned.
            neg_quo <= is_signed && (dividend[`XLEN-1] ^ divisor[`XLEN-1]) && (|divisor);
            neg_rem <= is_signed && dividend[`XLEN-1];
        end
        else if (busy)
        begin
            quo_r <= {quo_r[`XLEN-2:0], ~diff[`XLEN]};
            rem_r <= diff[`XLEN] ? shifted[`XLEN-1:0] : diff[`XLEN-1:0];
        end
    end

    assign quotient  = neg_quo ? -quo_r : quo_r;
    assign remainder = neg_rem ? -rem_r : rem_r;

    // the execute stage may only launch a new divide once the last one has finished.
    assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else $error("divider start while busy.");

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu
    import cpu_pkg::*;
(
    input  alu_op_t          alu_op,
    input  logic [`XLEN-1:0] alu_src1,
    input  logic [`XLEN-1:0] alu_src2,
    output logic [`XLEN-1:0] alu_result
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = alu_src2[SHAMT_W-1:0];
    assign lt_signed   = $signed(alu_src1) < $signed(alu_src2);
    assign lt_unsigned = alu_src1 < alu_src2;

    always_comb
    begin
        case (alu_op)
            alu_add:  alu_result = alu_src1 + alu_src2;
            alu_sub:  alu_result = alu_src1 - alu_src2;
            alu_slt:  alu_result = {{(`XLEN-1){1'b0}}, lt_signed};
            alu_sltu: alu_result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            alu_and:  alu_result = alu_src1 & alu_src2;
            alu_or:   alu_result = alu_src1 | alu_src2;
            alu_nor:  alu_result = ~(alu_src1 | alu_src2);
            alu_xor:  alu_result = alu_src1 ^ alu_src2;
            alu_sll:  alu_result = alu_src1 << shamt;
            alu_srl:  alu_result = alu_src1 >> shamt;
            alu_sra:  alu_result = $unsigned($signed(alu_src1) >>> shamt);
            alu_lui:  alu_result = alu_src2;    // decode already placed the upper immediate.
            default:  alu_result = '0;
        endcase
    end

endmodule

// File: logic/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_nor,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        md_none,
        md_mul,
        md_mulh,
        md_mulhu,
        md_div,
        md_mod,
        md_divu,
        md_modu
    } md_op_t;

    typedef enum logic [3:0] {
        mem_none,
        mem_ld_b,
        mem_ld_h,
        mem_ld_w,
        mem_ld_bu,
        mem_ld_hu,
        mem_st_b,
        mem_st_h,
        mem_st_w
    } mem_op_t;

    typedef struct packed {
        alu_op_t          alu_op;
        md_op_t           md_op;
        mem_op_t          mem_op;
        logic             src1_is_pc;
        logic             src2_is_imm;
        logic             gr_we;
        logic [4:0]       dest;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] rj_value;
        logic [`XLEN-1:0] rkd_value;
        logic [`XLEN-1:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        mem_op_t          mem_op;
        logic             gr_we;
        logic [4:0]       dest;
        logic [1:0]       byte_off;    // low address bits for load alignment.
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] pc;
    } es_to_ms_t;

    typedef struct packed {
        logic             gr_we;
        logic [4:0]       dest;
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] pc;
    } ms_to_ws_t;

    typedef struct packed {
        logic             valid;
        logic             blocked;     // value not known yet, decode must stall.
        logic [4:0]       dest;
        logic [`XLEN-1:0] value;
    } fwd_t;

endpackage

// File: logic/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path and address width in bits.
`define XLEN 32

// word address width of the data RAM, 1024 words.
`define DMEM_AW 10

// one quotient bit per divider step.
`define DIV_STEPS 32

`endif
